/* logic/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// data width of every CSR and of the rs1 operand.
`define CSR_XLEN 32

// machine-mode CSR addresses that the unit decodes.
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MIE      12'h304
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MCAUSE   12'h342

// low two bits of funct3. Bit 2 picks the immediate instead of rs1.
`define CSR_F3_RW 2'd1
`define CSR_F3_RS 2'd2
`define CSR_F3_RC 2'd3

`endif

/* logic/csr_pkg.sv */
`default_nettype none
`include "csr_defs.svh"

package csr_pkg;

   // how the bit written back is formed from the old bit and d.
   typedef enum logic [1:0] {
      SRC_CSR = 2'd0, // keep the old bit.
      SRC_EXT = 2'd1, // take d as it is.
      SRC_SET = 2'd2, // old bit or d.
      SRC_CLR = 2'd3  // old bit and not d.
   } csr_src_e;

   // one CSR instruction as the controller hands it over.
   typedef struct packed {
      logic [11:0]          addr;
      logic [2:0]           funct3;
      logic [`CSR_XLEN-1:0] rs1;
      logic [4:0]           imm;    // zero-extended when used.
   } csr_cmd_t;

   // why a trap was taken.
   typedef struct packed {
      logic is_irq;   // timer interrupt.
      logic e_op;     // ecall or ebreak.
      logic ebreak;   // set for ebreak, clear for ecall.
      logic misalign; // misaligned memory access.
      logic mem_cmd;  // a store when set, a load otherwise.
   } trap_cause_t;

   // per-instruction control from decode to the bit slice.
   typedef struct packed {
      logic     mstatus_en;
      logic     mie_en;
      logic     mcause_en;
      logic     mscratch_en;
      logic     mtvec_en;
      logic     d_sel;      // immediate when set, rs1 otherwise.
      csr_src_e source;
   } bit_ctl_t;

   // bit counter phases. All of them are low outside the 32 bit cycles.
   typedef struct packed {
      logic en;
      logic cnt0to3;
      logic cnt3;
      logic cnt7;
      logic cnt_done;
   } bit_phase_t;

endpackage

`default_nettype wire

/* logic/csr_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

// runs one CSR command through the serial datapath.
// The operand leaves lsb first and the old CSR value comes back lsb first.
module csr_sequencer (
   input  wire                      i_clk,
   input  wire                      i_rst_n,
   input  wire                      i_start,
   input  wire csr_pkg::csr_cmd_t   i_cmd,
   input  wire                      i_q,       // old CSR bit of this cycle.
   output logic                     o_busy,
   output logic                     o_done,
   output csr_pkg::bit_phase_t      o_phase,
   output csr_pkg::csr_cmd_t        o_cmd,
   output logic                     o_rs1_bit,
   output logic                     o_imm_bit,
   output logic [`CSR_XLEN-1:0]     o_rd
);

   localparam int CNT_W = $clog2(`CSR_XLEN);

   logic                 run;       // high during the 32 bit cycles only.
   logic [CNT_W-1:0]     cnt;       // index of the bit in flight.
   logic                 cnt_last;
   logic                 start_ok;
   csr_pkg::csr_cmd_t    cmd_q;
   logic [`CSR_XLEN-1:0] rs1_sr;
   logic [4:0]           imm_sr;
   logic [`CSR_XLEN-1:0] rd_sr;
   logic [`CSR_XLEN-1:0] rd_next;

   assign start_ok = i_start & ~o_busy; // a start while busy is dropped.
   assign cnt_last = (cnt == CNT_W'(`CSR_XLEN - 1));
   assign rd_next  = {i_q, rd_sr[`CSR_XLEN-1:1]}; // old value enters at the top.

   // the phases are qualified with run, so the slice sees nothing while idle.
   assign o_phase.en       = run;
   assign o_phase.cnt0to3  = run & (cnt < CNT_W'(4));
   assign o_phase.cnt3     = run & (cnt == CNT_W'(3));
   assign o_phase.cnt7     = run & (cnt == CNT_W'(7));
   assign o_phase.cnt_done = run & cnt_last;

   assign o_cmd     = cmd_q;
   assign o_rs1_bit = rs1_sr[0];
   assign o_imm_bit = imm_sr[0];

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_busy <= 1'b0;
         run    <= 1'b0;
         o_done <= 1'b0;
         cnt    <= '0;
      end else begin
         o_done <= run & cnt_last; // one cycle after the last bit.
         if (start_ok) begin
            o_busy <= 1'b1;
            run    <= 1'b1;
            cnt    <= '0;
         end else if (run) begin
            cnt <= cnt + CNT_W'(1); // wraps back to zero after bit 31.
            if (cnt_last)
               run <= 1'b0;
         end else if (o_done) begin
            o_busy <= 1'b0; // busy also covers the done cycle.
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (start_ok) begin
         cmd_q  <= i_cmd;
         rs1_sr <= i_cmd.rs1;
         imm_sr <= i_cmd.imm;
      end else if (run) begin
         rs1_sr <= rs1_sr >> 1;
         imm_sr <= imm_sr >> 1; // zeros follow, so the immediate is zero-extended.
      end
      if (run)
         rd_sr <= rd_next;
      // o_rd is loaded only once per command and holds until the next done.
      if (run & cnt_last)
         o_rd <= rd_next;
   end

endmodule

`default_nettype wire

/* logic/csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

// turns the latched command into the register enables and the source select.
module csr_decode (
   input  wire csr_pkg::csr_cmd_t i_cmd,
   output csr_pkg::bit_ctl_t      o_ctl
);

   logic     op_valid;   // funct3 names one of the six CSR instructions.
   logic     hit_mstatus;
   logic     hit_mie;
   logic     hit_mcause;
   logic     hit_mscratch;
   logic     hit_mtvec;
   csr_pkg::csr_src_e src;

   assign op_valid = (i_cmd.funct3[1:0] != 2'd0);

   always_comb begin
      hit_mstatus  = 1'b0;
      hit_mie      = 1'b0;
      hit_mcause   = 1'b0;
      hit_mscratch = 1'b0;
      hit_mtvec    = 1'b0;
      // an address outside this list selects nothing and reads as zero.
      case (i_cmd.addr)
         `CSR_ADDR_MSTATUS:  hit_mstatus  = 1'b1;
         `CSR_ADDR_MIE:      hit_mie      = 1'b1;
         `CSR_ADDR_MCAUSE:   hit_mcause   = 1'b1;
         `CSR_ADDR_MSCRATCH: hit_mscratch = 1'b1;
         `CSR_ADDR_MTVEC:    hit_mtvec    = 1'b1;
         default: ;
      endcase
   end

   always_comb begin
      case (i_cmd.funct3[1:0])
         `CSR_F3_RW: src = csr_pkg::SRC_EXT;
         `CSR_F3_RS: src = csr_pkg::SRC_SET;
         `CSR_F3_RC: src = csr_pkg::SRC_CLR;
         default:    src = csr_pkg::SRC_CSR; // not a CSR op, keep everything.
      endcase
   end

   // with an invalid funct3 no register is touched at all.
   assign o_ctl.mstatus_en  = op_valid & hit_mstatus;
   assign o_ctl.mie_en      = op_valid & hit_mie;
   assign o_ctl.mcause_en   = op_valid & hit_mcause;
   assign o_ctl.mscratch_en = op_valid & hit_mscratch;
   assign o_ctl.mtvec_en    = op_valid & hit_mtvec;
   assign o_ctl.d_sel       = i_cmd.funct3[2];  // csrrwi, csrrsi and csrrci.
   // an unknown address also keeps the old bit.
   assign o_ctl.source      = (hit_mstatus | hit_mie | hit_mcause |
                               hit_mscratch | hit_mtvec) ? src : csr_pkg::SRC_CSR;

endmodule

`default_nettype wire

/* logic/csr_machine_state.sv */
`timescale 1ns/1ps
`default_nettype none

// the bit slice of the CSR unit and the machine state that lives in flops.
// It holds the MIE, MPIE and MTIE bits and mcause. The full word registers
// sit in the scratch store and arrive here on i_rf_csr_out.
module csr_machine_state (
   input  wire                        i_clk,
   input  wire                        i_rst_n,
   input  wire csr_pkg::bit_phase_t   i_phase,
   input  wire csr_pkg::bit_ctl_t     i_ctl,
   input  wire                        i_rf_csr_out, // old bit from the scratch store.
   input  wire                        i_rs1,
   input  wire                        i_csr_imm,
   input  wire                        i_trap,
   input  wire csr_pkg::trap_cause_t  i_cause,
   input  wire                        i_mret,
   input  wire                        i_mtip,
   output logic                       o_csr_in,     // new bit to be written.
   output logic                       o_q,          // old bit, goes to rd.
   output logic                       o_new_irq
);

   logic       mstatus_mie;
   logic       mstatus_mpie;  // saved MIE. Software cannot see it.
   logic       mie_mtie;
   logic       mcause31;
   logic [3:0] mcause3_0;     // rotates one place per bit cycle 0 to 3.
   logic       mcause_bit;
   logic       d;
   logic       csr_out;
   logic       trap_taken;
   logic       mret_taken;
   logic [3:0] trap_code;
   logic       timer_irq;
   logic       timer_irq_r;

   // trap and mret only act when no bit cycle is in flight.
   assign trap_taken = i_trap & ~i_phase.en;
   assign mret_taken = i_mret & ~i_phase.en;

   assign d = i_ctl.d_sel ? i_csr_imm : i_rs1;

   // mcause shows its code on bits 0 to 3 and its flag on bit 31.
   assign mcause_bit = i_phase.cnt0to3  ? mcause3_0[0] :
                       i_phase.cnt_done ? mcause31 :
                       1'b0;

   // mie is write-only here and so never adds to the read value.
   assign csr_out = (i_ctl.mstatus_en & mstatus_mie & i_phase.cnt3) |
                    i_rf_csr_out |
                    (i_ctl.mcause_en & mcause_bit);

   always_comb begin
      case (i_ctl.source)
         csr_pkg::SRC_EXT: o_csr_in = d;
         csr_pkg::SRC_SET: o_csr_in = csr_out | d;
         csr_pkg::SRC_CLR: o_csr_in = csr_out & ~d;
         default:          o_csr_in = csr_out; // SRC_CSR writes the old bit back.
      endcase
   end

   assign o_q = csr_out;

   // code for a trap.
   // ecall is 11 and ebreak is 3, a misaligned load 4 and a store 6.
   always_comb begin
      if (i_cause.is_irq)
         trap_code = 4'd7;                             // machine timer interrupt.
      else if (i_cause.e_op)
         trap_code = {~i_cause.ebreak, 3'b011};
      else if (i_cause.misalign)
         trap_code = {2'b01, i_cause.mem_cmd, 1'b0};
      else
         trap_code = 4'd0;
   end

   assign timer_irq = i_mtip & mstatus_mie & mie_mtie;
   assign o_new_irq = timer_irq & ~timer_irq_r; // only on the rising condition.

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mie_mtie     <= 1'b0;
         timer_irq_r  <= 1'b0;
      end else begin
         timer_irq_r <= timer_irq;

         // MTIE is bit 7 of mie.
         if (i_ctl.mie_en & i_phase.cnt7)
            mie_mtie <= o_csr_in;

         // a trap clears MIE, mret restores it from MPIE, and a write
         // to mstatus takes bit 3. Only one of these happens in a cycle.
         if (trap_taken | mret_taken | (i_ctl.mstatus_en & i_phase.cnt3))
            mstatus_mie <= ~trap_taken & (mret_taken ? mstatus_mpie : o_csr_in);

         if (trap_taken)
            mstatus_mpie <= mstatus_mie;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         mcause3_0 <= 4'd0;
         mcause31  <= 1'b0;
      end else begin
         // the written bit enters at the top while the old one leaves at 0.
         if (trap_taken)
            mcause3_0 <= trap_code;
         else if (i_ctl.mcause_en & i_phase.cnt0to3)
            mcause3_0 <= {o_csr_in, mcause3_0[3:1]};

         if (trap_taken)
            mcause31 <= i_cause.is_irq;
         else if (i_ctl.mcause_en & i_phase.cnt_done)
            mcause31 <= o_csr_in;
      end
   end

endmodule

`default_nettype wire

/* logic/csr_scratch_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

// mscratch and mtvec as two circulating shift registers.
// Both turn by one bit on every bit cycle, so after the 32 cycles of a
// command they are back in their resting alignment with bit 0 at the exit.
module csr_scratch_store (
   input  wire                      i_clk,
   input  wire                      i_rst_n,
   input  wire csr_pkg::bit_phase_t i_phase,
   input  wire csr_pkg::bit_ctl_t   i_ctl,
   input  wire                      i_csr_in,     // bit to store in the selected register.
   output logic                     o_rf_csr_out  // current bit of the selected register.
);

   logic [`CSR_XLEN-1:0] mscratch;
   logic [`CSR_XLEN-1:0] mtvec;
   logic                 mscratch_next;
   logic                 mtvec_next;

   // a selected register takes the new bit. The other one keeps its own.
   assign mscratch_next = i_ctl.mscratch_en ? i_csr_in : mscratch[0];
   assign mtvec_next    = i_ctl.mtvec_en    ? i_csr_in : mtvec[0];

   // zero when neither register is addressed, so the slice can simply or it in.
   assign o_rf_csr_out = (i_ctl.mscratch_en & mscratch[0]) |
                         (i_ctl.mtvec_en    & mtvec[0]);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         mscratch <= '0;
         mtvec    <= '0;
      end else if (i_phase.en) begin
         // bit 0 leaves and the next value enters at the top.
         mscratch <= {mscratch_next, mscratch[`CSR_XLEN-1:1]};
         mtvec    <= {mtvec_next, mtvec[`CSR_XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

/* logic/csr_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

// top of the CSR unit.
// The sequencer feeds the operand one bit per cycle into the bit slice, the
// slice and the scratch store swap old and new bits, and the old value
// goes back into the sequencer to build rd.
module csr_unit_top (
   input  wire                       i_clk,
   input  wire                       i_rst_n,
   input  wire                       i_start,
   input  wire csr_pkg::csr_cmd_t    i_cmd,
   input  wire                       i_trap,
   input  wire csr_pkg::trap_cause_t i_cause,
   input  wire                       i_mret,
   input  wire                       i_mtip,
   output logic                      o_busy,
   output logic                      o_done,
   output logic [`CSR_XLEN-1:0]      o_rd,
   output logic                      o_new_irq
);

   csr_pkg::csr_cmd_t   cmd_q;       // command held for the whole transfer.
   csr_pkg::bit_phase_t phase;
   csr_pkg::bit_ctl_t   ctl;
   logic                rs1_bit;
   logic                imm_bit;
   logic                q_bit;       // old CSR bit back to the sequencer.
   logic                csr_in_bit;  // new CSR bit to the scratch store.
   logic                rf_csr_out;  // old bit of mscratch or mtvec.

   csr_sequencer u_csr_sequencer (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_start   (i_start),
      .i_cmd     (i_cmd),
      .i_q       (q_bit),
      .o_busy    (o_busy),
      .o_done    (o_done),
      .o_phase   (phase),
      .o_cmd     (cmd_q),
      .o_rs1_bit (rs1_bit),
      .o_imm_bit (imm_bit),
      .o_rd      (o_rd)
   );

   csr_decode u_csr_decode (
      .i_cmd (cmd_q),
      .o_ctl (ctl)
   );

   csr_machine_state u_csr_machine_state (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_phase      (phase),
      .i_ctl        (ctl),
      .i_rf_csr_out (rf_csr_out),
      .i_rs1        (rs1_bit),
      .i_csr_imm    (imm_bit),
      .i_trap       (i_trap),
      .i_cause      (i_cause),
      .i_mret       (i_mret),
      .i_mtip       (i_mtip),
      .o_csr_in     (csr_in_bit),
      .o_q          (q_bit),
      .o_new_irq    (o_new_irq)
   );

   csr_scratch_store u_csr_scratch_store (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_phase      (phase),
      .i_ctl        (ctl),
      .i_csr_in     (csr_in_bit),
      .o_rf_csr_out (rf_csr_out)
   );

endmodule

`default_nettype wire

/* testbench/tb_csr_tasks.svh */
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

// expected CSR state. mie reads as zero, so nothing is kept for it.
logic        m_mie;
logic        m_mpie;
logic [3:0]  m_code;
logic        m_flag;
logic [31:0] m_scratch;
logic [31:0] m_tvec;

// the word a read of addr returns, with only the implemented bits showing.
function automatic logic [31:0] model_read(input logic [11:0] addr);
   case (addr)
      `CSR_ADDR_MSTATUS:  return {28'd0, m_mie, 3'd0};
      `CSR_ADDR_MCAUSE:   return {m_flag, 27'd0, m_code};
      `CSR_ADDR_MSCRATCH: return m_scratch;
      `CSR_ADDR_MTVEC:    return m_tvec;
      default:            return 32'd0; // mie and unknown addresses.
   endcase
endfunction

function automatic logic [31:0] csr_rule(input logic [1:0] op, input logic [31:0] old_val,
                                         input logic [31:0] d);
   case (op)
      `CSR_F3_RW: return d;
      `CSR_F3_RS: return old_val | d;
      `CSR_F3_RC: return old_val & ~d;
      default:    return old_val;
   endcase
endfunction

// exception code that a trap of this kind leaves in mcause.
function automatic logic [3:0] cause_code(input csr_pkg::trap_cause_t c);
   if (c.is_irq)
      return 4'd7;
   else if (c.e_op)
      return c.ebreak ? 4'd3 : 4'd11;
   else if (c.misalign)
      return c.mem_cmd ? 4'd6 : 4'd4;
   return 4'd0;
endfunction

task automatic model_write(input logic [11:0] addr, input logic [31:0] val);
   case (addr)
      `CSR_ADDR_MSTATUS:  m_mie = val[3];
      `CSR_ADDR_MCAUSE: begin
         m_flag = val[31];
         m_code = val[3:0];
      end
      `CSR_ADDR_MSCRATCH: m_scratch = val;
      `CSR_ADDR_MTVEC:    m_tvec = val;
      default: ;                            // unknown addresses keep everything.
   endcase
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
   assert (act === exp)
   else begin
      $display("FAILED %s: expected %08h, actual %08h", name, exp, act);
      errors++;
   end
endtask

// hands one command to the DUT and waits for done, counting cycles from start.
task automatic issue_cmd(input logic [11:0] addr, input logic [2:0] f3,
                         input logic [31:0] rs1, input logic [4:0] imm,
                         output logic [31:0] rd, output int cycles);
   @(negedge i_clk);
   i_cmd.addr   = addr;
   i_cmd.funct3 = f3;
   i_cmd.rs1    = rs1;
   i_cmd.imm    = imm;
   i_start      = 1'b1;
   @(negedge i_clk);
   cycles = 1;
   while (!o_done && cycles < DONE_TIMEOUT) begin
      if (cycles == poke_at) begin
         i_start   = 1'b1;            // a second start while busy.
         i_cmd.rs1 = ~i_cmd.rs1;
      end else begin
         i_start = 1'b0;
      end
      @(negedge i_clk);
      cycles++;
   end
   i_start = 1'b0;
   if (!o_done) begin
      $display("timeout: no done from the DUT within %0d cycles", DONE_TIMEOUT);
      timeouts++;
   end
   rd = o_rd;
endtask

// runs one command and checks the old value and the latency against the model.
task automatic csr_op(input string name, input logic [11:0] addr, input logic [2:0] f3,
                      input logic [31:0] rs1, input logic [4:0] imm);
   logic [31:0] old_val;
   logic [31:0] d;
   logic [31:0] rd;
   int          cycles;
   old_val = model_read(addr);
   d       = f3[2] ? {27'd0, imm} : rs1;  // immediates are zero-extended.
   issue_cmd(addr, f3, rs1, imm, rd, cycles);
   check_value({name, " rd"}, old_val, rd);
   check_value({name, " latency"}, 32'd33, 32'(cycles));
   model_write(addr, csr_rule(f3[1:0], old_val, d));
endtask

task automatic verify_all(input string name);
   csr_op({name, " mstatus"}, `CSR_ADDR_MSTATUS, 3'b010, 32'd0, 5'd0);
   csr_op({name, " mie"}, `CSR_ADDR_MIE, 3'b010, 32'd0, 5'd0);
   csr_op({name, " mcause"}, `CSR_ADDR_MCAUSE, 3'b010, 32'd0, 5'd0);
   csr_op({name, " mscratch"}, `CSR_ADDR_MSCRATCH, 3'b010, 32'd0, 5'd0);
   csr_op({name, " mtvec"}, `CSR_ADDR_MTVEC, 3'b010, 32'd0, 5'd0);
endtask

task automatic take_trap(input csr_pkg::trap_cause_t cause);
   @(negedge i_clk);
   i_cause = cause;
   i_trap  = 1'b1;
   @(negedge i_clk);
   i_trap = 1'b0;
   m_mpie = m_mie;                    // MIE is saved and then cleared.
   m_mie  = 1'b0;
   m_code = cause_code(cause);
   m_flag = cause.is_irq;
endtask

task automatic do_mret();
   @(negedge i_clk);
   i_mret = 1'b1;
   @(negedge i_clk);
   i_mret = 1'b0;
   m_mie  = m_mpie;
endtask

// counts cycles with o_new_irq high, sampled in the middle of each cycle.
task automatic count_irq_pulses(input int n, output int count);
   count = 0;
   repeat (n) begin
      #(CLK_PERIOD / 4);
      if (o_new_irq)
         count++;
      @(negedge i_clk);
   end
endtask

`endif

/* testbench/tb_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_defs.svh"

module tb_csr_unit;

   localparam int CLK_PERIOD   = 100;
   localparam int DONE_TIMEOUT = 100;  // cycles one command may take.

   logic                 i_clk;
   logic                 i_rst_n;
   logic                 i_start;
   csr_pkg::csr_cmd_t    i_cmd;
   logic                 i_trap;
   csr_pkg::trap_cause_t i_cause;
   logic                 i_mret;
   logic                 i_mtip;
   logic                 o_busy;
   logic                 o_done;
   logic [31:0]          o_rd;
   logic                 o_new_irq;
   int                   errors;
   int                   timeouts;
   int                   poke_at;      // cycle of an extra start inside a command. Zero means none.
   int                   pulses;
   logic [2:0]           ops [6];
   logic [4:0]           kinds [6];    // irq, ecall, ebreak, misaligned load and store, none.

   `include "tb_csr_tasks.svh"

   csr_unit_top u_csr_unit_top (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_start   (i_start),
      .i_cmd     (i_cmd),
      .i_trap    (i_trap),
      .i_cause   (i_cause),
      .i_mret    (i_mret),
      .i_mtip    (i_mtip),
      .o_busy    (o_busy),
      .o_done    (o_done),
      .o_rd      (o_rd),
      .o_new_irq (o_new_irq)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   initial begin
      i_rst_n   = 1'b0;
      i_start   = 1'b0;
      i_cmd     = '0;
      i_trap    = 1'b0;
      i_cause   = '0;
      i_mret    = 1'b0;
      i_mtip    = 1'b0;
      errors    = 0;
      timeouts  = 0;
      poke_at   = 0;
      m_mie     = 1'b0;
      m_mpie    = 1'b0;
      m_code    = 4'd0;
      m_flag    = 1'b0;
      m_scratch = 32'd0;
      m_tvec    = 32'd0;
      ops       = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
      kinds     = '{5'b10000, 5'b01000, 5'b01100, 5'b00010, 5'b00011, 5'b00000};
      void'($urandom(32'hfe47_f038));
      repeat (3) @(posedge i_clk);
      @(negedge i_clk);
      i_rst_n = 1'b1;
      check_value("reset outputs", 32'd0, {29'd0, o_busy, o_done, o_new_irq});

      // full writes first, then every op kind with random operands.
      csr_op("mscratch csrrw", `CSR_ADDR_MSCRATCH, 3'b001, $urandom(), 5'd0);
      csr_op("mtvec csrrw", `CSR_ADDR_MTVEC, 3'b001, $urandom(), 5'd0);
      for (int i = 0; i < 6; i++) begin
         csr_op($sformatf("mscratch f3=%0d", ops[i]), `CSR_ADDR_MSCRATCH, ops[i],
                $urandom(), 5'($urandom()));
         csr_op($sformatf("mtvec f3=%0d", ops[i]), `CSR_ADDR_MTVEC, ops[i],
                $urandom(), 5'($urandom()));
      end
      verify_all("scratch read");

      // the extra start lands mid-command and must leave no trace.
      poke_at = 10;
      csr_op("start while busy", `CSR_ADDR_MSCRATCH, 3'b001, $urandom(), 5'd0);
      poke_at = 0;
      repeat (3) begin
         @(negedge i_clk);
         check_value("idle after done", 32'd0, {30'd0, o_busy, o_done});
      end
      verify_all("after busy start");

      csr_op("mstatus csrrw", `CSR_ADDR_MSTATUS, 3'b001, 32'hffff_ffff, 5'd0);
      csr_op("mstatus read", `CSR_ADDR_MSTATUS, 3'b010, 32'd0, 5'd0);
      take_trap(csr_pkg::trap_cause_t'(5'b01000));
      csr_op("mstatus after trap", `CSR_ADDR_MSTATUS, 3'b010, 32'd0, 5'd0);
      do_mret();
      csr_op("mstatus after mret", `CSR_ADDR_MSTATUS, 3'b010, 32'd0, 5'd0);

      for (int i = 0; i < 6; i++) begin
         take_trap(csr_pkg::trap_cause_t'(kinds[i]));
         csr_op($sformatf("mcause kind %0d", i), `CSR_ADDR_MCAUSE, 3'b010, 32'd0, 5'd0);
      end
      // MPIE now holds a cleared MIE, so mret must leave MIE clear.
      do_mret();
      csr_op("mstatus after mret of clear", `CSR_ADDR_MSTATUS, 3'b010, 32'd0, 5'd0);
      csr_op("mcause csrrw", `CSR_ADDR_MCAUSE, 3'b001, 32'hffff_ffff, 5'd0);
      csr_op("mcause read", `CSR_ADDR_MCAUSE, 3'b010, 32'd0, 5'd0);

      // timer interrupt with MIE and MTIE both set by commands.
      csr_op("mstatus set mie", `CSR_ADDR_MSTATUS, 3'b110, 32'd0, 5'd8);
      csr_op("mie write", `CSR_ADDR_MIE, 3'b001, 32'h0000_0080, 5'd0);
      @(negedge i_clk);
      i_mtip = 1'b1;
      count_irq_pulses(4, pulses);
      check_value("irq first pulse", 32'd1, 32'(pulses));
      count_irq_pulses(4, pulses);           // mtip is still held high here.
      check_value("irq held", 32'd0, 32'(pulses));
      i_mtip = 1'b0;
      csr_op("mstatus clear mie", `CSR_ADDR_MSTATUS, 3'b111, 32'd0, 5'd8);
      @(negedge i_clk);
      i_mtip = 1'b1;
      count_irq_pulses(4, pulses);
      check_value("irq with mie clear", 32'd0, 32'(pulses));
      i_mtip = 1'b0;

      csr_op("unknown csrrw", 12'h7c0, 3'b001, $urandom(), 5'd0);
      csr_op("unknown csrrsi", 12'h7c0, 3'b110, 32'd0, 5'h1f);
      verify_all("after unknown");

      $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
+incdir+testbench
logic/csr_pkg.sv
logic/csr_sequencer.sv
logic/csr_decode.sv
logic/csr_machine_state.sv
logic/csr_scratch_store.sv
logic/csr_unit_top.sv
testbench/tb_csr_unit.sv

/* Makefile */
# Verilator build and run of the CSR unit testbench.
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "make clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_csr_unit -f verilog.f
	./obj_dir/Vtb_csr_unit > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
